//--- design/cdb_pkg.sv
package cdb_pkg;

    // physical register tags and result words
    localparam int tag_width  = 6;
    localparam int data_width = 32;

    // result bus slots, lower index wins on a tag collision
    localparam int bus_alu  = 0;
    localparam int bus_mul  = bus_alu + 1;
    localparam int bus_div  = bus_mul + 1;
    localparam int bus_load = bus_div + 1;

    localparam int num_buses = bus_load + 1;

    // one broadcast, valid for a single cycle
    typedef struct packed {
        logic                  valid;
        logic [tag_width-1:0]  tag;
        logic [data_width-1:0] data;
    } result_bus_t;

endpackage

//--- design/rs_pkg.sv
package rs_pkg;

    localparam int rs_depth  = 16;
    localparam int idx_width = $clog2(rs_depth);
    localparam int pc_width  = 32;

    typedef logic [idx_width-1:0] idx_t;

    // passed to the divider untouched
    typedef enum logic [1:0] {
        op_div,
        op_divu,
        op_rem,
        op_remu
    } div_op_e;

    typedef struct packed {
        logic                           valid;
        logic [cdb_pkg::tag_width-1:0]  tag;
        logic [cdb_pkg::data_width-1:0] data;
    } src_t;

    typedef struct packed {
        logic                          valid;  // dispatch strobe
        logic [pc_width-1:0]           pc;
        logic [cdb_pkg::tag_width-1:0] rd;
        div_op_e                       op;
        src_t                          src1;
        src_t                          src2;
    } dispatch_t;

    typedef struct packed {
        logic                           valid;
        logic [pc_width-1:0]            pc;
        logic [cdb_pkg::tag_width-1:0]  rd;
        div_op_e                        op;
        logic [cdb_pkg::data_width-1:0] src1_data;
        logic [cdb_pkg::data_width-1:0] src2_data;
    } issue_t;

    // payload of one station slot
    typedef struct packed {
        logic [pc_width-1:0]           pc;
        logic [cdb_pkg::tag_width-1:0] rd;
        div_op_e                       op;
        src_t                          src1;
        src_t                          src2;
    } entry_data_t;

    typedef struct packed {
        logic        busy;
        entry_data_t data;
    } rs_entry_t;

    // catch a waiting source from the result buses
    function automatic src_t snoop_src(
        input src_t                                           src,
        input cdb_pkg::result_bus_t [cdb_pkg::num_buses-1:0] buses
    );
        src_t res;
        res = src;
        if (!src.valid) begin
            // walk downward so the lowest matching bus is applied last
            for (int b = cdb_pkg::num_buses - 1; b >= 0; b--) begin
                if (buses[b].valid && buses[b].tag == src.tag) begin
                    res.valid = 1'b1;
                    res.data  = buses[b].data;
                end
            end
        end
        return res;
    endfunction

endpackage

//--- design/rs_operand_capture.sv
`timescale 1ns/1ns

module rs_operand_capture (
    input  rs_pkg::dispatch_t                             dispatch,
    input  cdb_pkg::result_bus_t [cdb_pkg::num_buses-1:0] buses,
    output rs_pkg::dispatch_t                             resolved
);

    rs_pkg::src_t src1_hit;
    rs_pkg::src_t src2_hit;

    // same-cycle bypass, a producer broadcasting now is not missed
    assign src1_hit = rs_pkg::snoop_src(dispatch.src1, buses);
    assign src2_hit = rs_pkg::snoop_src(dispatch.src2, buses);

    always_comb begin
        resolved       = dispatch;
        resolved.src1  = src1_hit;
        resolved.src2  = src2_hit;
    end

endmodule

//--- design/rs_entry_array.sv
`timescale 1ns/1ns

module rs_entry_array (
    input  logic                                          clk,
    input  logic                                          reset,
    input  rs_pkg::dispatch_t                             resolved,
    input  cdb_pkg::result_bus_t [cdb_pkg::num_buses-1:0] buses,
    input  logic                                          grant_valid,
    input  rs_pkg::idx_t                                  grant_idx,
    output rs_pkg::rs_entry_t                             entries [rs_pkg::rs_depth],
    output logic [rs_pkg::rs_depth-1:0]                   ready,
    output logic                                          full
);

    logic [rs_pkg::rs_depth-1:0] busy_q;
    rs_pkg::entry_data_t         data_q [rs_pkg::rs_depth];
    rs_pkg::idx_t                alloc_idx;
    logic                        do_write;

    // lowest free slot
    always_comb begin
        alloc_idx = '0;
        for (int i = rs_pkg::rs_depth - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                alloc_idx = rs_pkg::idx_t'(i);
            end
        end
    end

    assign full     = &busy_q;
    assign do_write = resolved.valid && !full;  // dispatch while full is dropped

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q <= '0;
        end else begin
            if (do_write) begin
                busy_q[alloc_idx] <= 1'b1;
            end
            if (grant_valid) begin
                busy_q[grant_idx] <= 1'b0;  // slot reusable next cycle
            end
        end
    end

    // wakeup of stored sources, then the new entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            if (busy_q[i]) begin
                data_q[i].src1 <= rs_pkg::snoop_src(data_q[i].src1, buses);
                data_q[i].src2 <= rs_pkg::snoop_src(data_q[i].src2, buses);
            end
        end
        if (do_write) begin
            data_q[alloc_idx] <= '{
                pc:   resolved.pc,
                rd:   resolved.rd,
                op:   resolved.op,
                src1: resolved.src1,
                src2: resolved.src2
            };
        end
    end

    always_comb begin
        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            entries[i].busy = busy_q[i];
            entries[i].data = data_q[i];
            ready[i] = busy_q[i] && data_q[i].src1.valid && data_q[i].src2.valid;
        end
    end

endmodule

//--- design/rs_issue_select.sv
`timescale 1ns/1ns

module rs_issue_select (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [rs_pkg::rs_depth-1:0] ready,
    input  rs_pkg::rs_entry_t           entries [rs_pkg::rs_depth],
    output logic                        grant_valid,
    output rs_pkg::idx_t                grant_idx,
    output rs_pkg::issue_t              issue
);

    rs_pkg::idx_t        head_q;
    rs_pkg::idx_t        cand;
    logic                issue_valid_q;
    rs_pkg::entry_data_t picked_q;

    // circular search starting at head
    always_comb begin
        grant_valid = 1'b0;
        grant_idx   = head_q;
        cand        = head_q;
        for (int off = rs_pkg::rs_depth - 1; off >= 0; off--) begin
            cand = head_q + rs_pkg::idx_t'(off);  // wraps at depth
            if (ready[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_q        <= '0;
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= grant_valid;  // one pulse per grant
            if (grant_valid) begin
                head_q <= grant_idx + rs_pkg::idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            picked_q <= entries[grant_idx].data;
        end
    end

    assign issue = '{
        valid:     issue_valid_q,
        pc:        picked_q.pc,
        rd:        picked_q.rd,
        op:        picked_q.op,
        src1_data: picked_q.src1.data,
        src2_data: picked_q.src2.data
    };

endmodule

//--- design/div_rs.sv
`timescale 1ns/1ns

module div_rs (
    input  logic                                          clk,
    input  logic                                          reset,
    input  rs_pkg::dispatch_t                             dispatch,
    input  cdb_pkg::result_bus_t [cdb_pkg::num_buses-1:0] buses,
    output rs_pkg::issue_t                                issue,
    output logic                                          full
);

    rs_pkg::dispatch_t           resolved;
    rs_pkg::rs_entry_t           entries [rs_pkg::rs_depth];
    logic [rs_pkg::rs_depth-1:0] ready;
    logic                        grant_valid;
    rs_pkg::idx_t                grant_idx;

    rs_operand_capture u_capture (
        .dispatch (dispatch),
        .buses    (buses),
        .resolved (resolved)
    );

    rs_entry_array u_entries (
        .clk         (clk),
        .reset       (reset),
        .resolved    (resolved),
        .buses       (buses),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .entries     (entries),
        .ready       (ready),
        .full        (full)
    );

    // pick and register toward the divider
    rs_issue_select u_select (
        .clk         (clk),
        .reset       (reset),
        .ready       (ready),
        .entries     (entries),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .issue       (issue)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;  // released with the stimulus offset
    end

endmodule

//--- testbench/div_rs_props.sv
`timescale 1ns/1ns

module div_rs_props (
    input logic           clk,
    input logic           reset,
    input rs_pkg::issue_t issue,
    input logic           full
);

    // output register held clear by the async reset
    issue_low_in_reset: assert property (
        @(posedge clk) reset |-> !issue.valid
    ) else $error("issue.valid high while reset is asserted");

    // a slot is only freed by an issue
    full_falls_on_issue: assert property (
        @(posedge clk) disable iff (reset) $fell(full) |-> issue.valid
    ) else $error("full fell without an issue in the cycle before");

    issue_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(issue.valid)
    ) else $error("issue.valid is unknown after reset");

endmodule

bind div_rs div_rs_props u_props (
    .clk   (clk),
    .reset (reset),
    .issue (issue),
    .full  (full)
);

//--- testbench/tb_div_rs.sv
`timescale 1ns/1ns

module tb_div_rs;

    typedef logic [cdb_pkg::tag_width-1:0] tag_t;
    typedef cdb_pkg::result_bus_t [cdb_pkg::num_buses-1:0] bus_vec_t;

    // dispatch cycles, then idle cycles, then the rds that should have issued
    typedef struct packed {
        logic                          disp;
        logic [4:0]                    reps;  // back to back dispatches, rd counts up
        tag_t                          rd;
        rs_pkg::div_op_e               op;
        logic                          s1_valid;
        tag_t                          s1_tag;
        logic                          s2_valid;
        tag_t                          s2_tag;
        logic [cdb_pkg::num_buses-1:0] bus_valid;
        tag_t [cdb_pkg::num_buses-1:0] bus_tag;
        logic [4:0]                    wait_cycles;
        tag_t                          exp_first;  // issued rds count up from here
        logic [4:0]                    exp_count;
    } row_t;

    logic              clk;
    logic              reset;
    rs_pkg::dispatch_t dispatch;
    bus_vec_t          buses;
    rs_pkg::issue_t    issue;
    logic              full;

    row_t  table_q [$];
    string name_q [$];
    string test_name;
    tag_t  issued_q [$];

    // model of the station
    logic [rs_pkg::rs_depth-1:0] m_busy;
    rs_pkg::entry_data_t         m_ent [rs_pkg::rs_depth];
    int                          m_head;

    logic [15:0] lfsr_state;
    int          pc_count;
    int          error_count;
    int          cycle_count;

    tb_clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    div_rs DUT (
        .clk      (clk),
        .reset    (reset),
        .dispatch (dispatch),
        .buses    (buses),
        .issue    (issue),
        .full     (full)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [31:0] next_random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // first valid bus in index order with a matching tag
    function automatic rs_pkg::src_t take_from_buses(input rs_pkg::src_t s, input bus_vec_t b);
        rs_pkg::src_t r;
        logic         hit;
        r   = s;
        hit = s.valid;
        for (int i = 0; i < cdb_pkg::num_buses; i++) begin
            if (!hit && b[i].valid && b[i].tag == s.tag) begin
                r.valid = 1'b1;
                r.data  = b[i].data;
                hit     = 1'b1;
            end
        end
        return r;
    endfunction

    task automatic report_mismatch(
        input string       what,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        error_count++;
        $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic add_row(
        input string                         name,
        input logic                          disp,
        input int                            reps,
        input int                            rd,
        input rs_pkg::div_op_e               op,
        input logic                          s1_valid,
        input int                            s1_tag,
        input logic                          s2_valid,
        input int                            s2_tag,
        input logic [cdb_pkg::num_buses-1:0] bus_valid,
        input tag_t [cdb_pkg::num_buses-1:0] bus_tag,
        input int                            wait_cycles,
        input int                            exp_first,
        input int                            exp_count
    );
        row_t row;
        row.disp        = disp;
        row.reps        = 5'(reps);
        row.rd          = tag_t'(rd);
        row.op          = op;
        row.s1_valid    = s1_valid;
        row.s1_tag      = tag_t'(s1_tag);
        row.s2_valid    = s2_valid;
        row.s2_tag      = tag_t'(s2_tag);
        row.bus_valid   = bus_valid;
        row.bus_tag     = bus_tag;
        row.wait_cycles = 5'(wait_cycles);
        row.exp_first   = tag_t'(exp_first);
        row.exp_count   = 5'(exp_count);
        table_q.push_back(row);
        name_q.push_back(name);
    endtask

    // name, disp, reps, rd, op, s1 valid/tag, s2 valid/tag,
    // bus mask, bus tags {load, div, mul, alu}, wait, first rd, rd count
    task automatic load_table();
        add_row("ready_dispatch", 1'b1, 1, 1, rs_pkg::op_div, 1'b1, 0, 1'b1, 0,
                4'b0000, '0, 2, 1, 1);
        add_row("wakeup_dispatch", 1'b1, 1, 2, rs_pkg::op_divu, 1'b0, 10, 1'b0, 11,
                4'b0000, '0, 1, 0, 0);
        add_row("wakeup_mul", 1'b0, 1, 0, rs_pkg::op_div, 1'b0, 0, 1'b0, 0,
                4'b0010, {6'd0, 6'd0, 6'd10, 6'd0}, 1, 0, 0);
        add_row("wakeup_load", 1'b0, 1, 0, rs_pkg::op_div, 1'b0, 0, 1'b0, 0,
                4'b1000, {6'd11, 6'd0, 6'd0, 6'd0}, 2, 2, 1);
        add_row("same_cycle_bypass", 1'b1, 1, 3, rs_pkg::op_rem, 1'b0, 12, 1'b0, 13,
                4'b1101, {6'd13, 6'd12, 6'd0, 6'd12}, 2, 3, 1);
        add_row("fill_station", 1'b1, 15, 32, rs_pkg::op_remu, 1'b0, 41, 1'b1, 0,
                4'b0000, '0, 0, 0, 0);
        add_row("fill_last_slot", 1'b1, 1, 47, rs_pkg::op_div, 1'b0, 40, 1'b1, 0,
                4'b0000, '0, 1, 0, 0);
        add_row("dispatch_when_full", 1'b1, 1, 63, rs_pkg::op_divu, 1'b0, 41, 1'b1, 0,
                4'b0000, '0, 1, 0, 0);
        add_row("drain_one", 1'b0, 1, 0, rs_pkg::op_div, 1'b0, 0, 1'b0, 0,
                4'b0010, {6'd0, 6'd0, 6'd40, 6'd0}, 2, 47, 1);
        add_row("drain_rest", 1'b0, 1, 0, rs_pkg::op_div, 1'b0, 0, 1'b0, 0,
                4'b1000, {6'd41, 6'd0, 6'd0, 6'd0}, 16, 32, 15);
        add_row("rotate_fill", 1'b1, 4, 4, rs_pkg::op_rem, 1'b0, 20, 1'b1, 0,
                4'b0000, '0, 0, 0, 0);
        add_row("rotate_wake", 1'b0, 1, 0, rs_pkg::op_div, 1'b0, 0, 1'b0, 0,
                4'b0001, {6'd0, 6'd0, 6'd0, 6'd20}, 1, 4, 1);
        add_row("rotate_refill", 1'b1, 1, 8, rs_pkg::op_divu, 1'b1, 0, 1'b1, 0,
                4'b0000, '0, 4, 5, 4);
    endtask

    // drive one cycle, advance the model across the edge, then compare
    task automatic step_cycle(input rs_pkg::dispatch_t d, input bus_vec_t b);
        rs_pkg::issue_t expect_issue;
        int             pick;
        int             free_slot;
        int             slot;
        logic           was_full;
        dispatch  = d;
        buses     = b;
        was_full  = &m_busy;
        free_slot = -1;
        pick      = -1;
        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            if (free_slot < 0 && !m_busy[i]) begin
                free_slot = i;
            end
        end
        for (int k = 0; k < rs_pkg::rs_depth; k++) begin
            slot = (m_head + k) % rs_pkg::rs_depth;
            if (pick < 0 && m_busy[slot] && m_ent[slot].src1.valid && m_ent[slot].src2.valid) begin
                pick = slot;
            end
        end
        expect_issue = '0;
        if (pick >= 0) begin
            expect_issue.valid     = 1'b1;
            expect_issue.pc        = m_ent[pick].pc;
            expect_issue.rd        = m_ent[pick].rd;
            expect_issue.op        = m_ent[pick].op;
            expect_issue.src1_data = m_ent[pick].src1.data;
            expect_issue.src2_data = m_ent[pick].src2.data;
        end
        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            if (m_busy[i]) begin
                m_ent[i].src1 = take_from_buses(m_ent[i].src1, b);
                m_ent[i].src2 = take_from_buses(m_ent[i].src2, b);
            end
        end
        if (pick >= 0) begin
            m_busy[pick] = 1'b0;
            m_head = (pick + 1) % rs_pkg::rs_depth;
        end
        if (d.valid && !was_full) begin
            m_ent[free_slot].pc   = d.pc;
            m_ent[free_slot].rd   = d.rd;
            m_ent[free_slot].op   = d.op;
            m_ent[free_slot].src1 = take_from_buses(d.src1, b);
            m_ent[free_slot].src2 = take_from_buses(d.src2, b);
            m_busy[free_slot] = 1'b1;
        end
        @(posedge clk);
        #10;
        cycle_count++;
        if (issue.valid !== expect_issue.valid) begin
            report_mismatch("issue valid", 32'(expect_issue.valid), 32'(issue.valid));
        end else if (expect_issue.valid) begin
            if (issue.rd !== expect_issue.rd) begin
                report_mismatch("issue rd", 32'(expect_issue.rd), 32'(issue.rd));
            end
            if (issue.pc !== expect_issue.pc) begin
                report_mismatch("issue pc", expect_issue.pc, issue.pc);
            end
            if (issue.op !== expect_issue.op) begin
                report_mismatch("issue op", 32'(expect_issue.op), 32'(issue.op));
            end
            if (issue.src1_data !== expect_issue.src1_data) begin
                report_mismatch("src1 data", expect_issue.src1_data, issue.src1_data);
            end
            if (issue.src2_data !== expect_issue.src2_data) begin
                report_mismatch("src2 data", expect_issue.src2_data, issue.src2_data);
            end
        end
        if (full !== (&m_busy)) begin
            report_mismatch("full", 32'(&m_busy), 32'(full));
        end
        if (issue.valid) begin
            issued_q.push_back(issue.rd);
        end
    endtask

    task automatic run_row(input int r);
        row_t              row;
        rs_pkg::dispatch_t d;
        bus_vec_t          b;
        row       = table_q[r];
        test_name = name_q[r];
        issued_q.delete();
        for (int n = 0; n < int'(row.reps); n++) begin
            d = '0;
            b = '0;
            if (row.disp) begin
                d.valid      = 1'b1;
                d.pc         = 32'h0000_1000 + 32'(pc_count * 4);
                d.rd         = row.rd + tag_t'(n);
                d.op         = row.op;
                d.src1.valid = row.s1_valid;
                d.src1.tag   = row.s1_tag;
                d.src2.valid = row.s2_valid;
                d.src2.tag   = row.s2_tag;
                if (row.s1_valid) begin
                    d.src1.data = next_random_word();
                end
                if (row.s2_valid) begin
                    d.src2.data = next_random_word();
                end
                pc_count++;
            end
            for (int i = 0; i < cdb_pkg::num_buses; i++) begin
                if (row.bus_valid[i]) begin
                    b[i].valid = 1'b1;
                    b[i].tag   = row.bus_tag[i];
                    b[i].data  = next_random_word();
                end
            end
            step_cycle(d, b);
        end
        repeat (int'(row.wait_cycles)) begin
            step_cycle('0, '0);
        end
        if (issued_q.size() != int'(row.exp_count)) begin
            error_count++;
            $display("error %s issue count: expected %0d, actual %0d",
                     test_name, row.exp_count, issued_q.size());
        end else begin
            for (int k = 0; k < issued_q.size(); k++) begin
                if (issued_q[k] !== row.exp_first + tag_t'(k)) begin
                    report_mismatch("issued rd", 32'(row.exp_first + tag_t'(k)),
                                    32'(issued_q[k]));
                end
            end
        end
    endtask

    initial begin
        dispatch    = '0;
        buses       = '0;
        m_busy      = '0;
        m_head      = 0;
        lfsr_state  = 16'd18;
        pc_count    = 0;
        error_count = 0;
        cycle_count = 0;
        test_name   = "reset";
        load_table();
        @(negedge reset);
        for (int r = 0; r < table_q.size(); r++) begin
            run_row(r);
        end
        $display("errors: %0d, cycles checked: %0d", error_count, cycle_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        @(negedge reset);
        repeat (table_q.size() * 20 + 50) begin
            @(posedge clk);
        end
        $display("watchdog expired before all rows were applied");
        $display("Test failed");
        $finish;
    end

endmodule

//--- compile.f
design/cdb_pkg.sv
design/rs_pkg.sv
design/rs_operand_capture.sv
design/rs_entry_array.sv
design/rs_issue_select.sv
design/div_rs.sv
testbench/tb_clock_gen.sv
testbench/div_rs_props.sv
testbench/tb_div_rs.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_div_rs \
    --Mdir obj_dir \
    -f compile.f

out=$(./obj_dir/Vtb_div_rs 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
